/* bench/conv_tile_chk.sv */
`timescale 1ns/1ns

// timing rules of the tile controller
module conv_tile_chk (
  input logic                        clk,
  input logic                        reset,
  input logic                        term_active,
  input logic                        sum_mult_e_en,
  input logic [accel_pkg::IDX_W-1:0] row_idx,
  input logic                        relu_scale_add_end
);

  int drain_len;   // drain cycles seen so far

  always_ff @(posedge clk) begin
    if (reset || !sum_mult_e_en) begin
      drain_len <= 0;
    end else begin
      drain_len <= drain_len + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // drain window
  ////////////////////////////////////////////////////////////////////////////
  a_drain_max: assert property (@(posedge clk) disable iff (reset)
    sum_mult_e_en |-> drain_len < accel_pkg::N_PE)
    else $error("drain window longer than %0d cycles", accel_pkg::N_PE);

  a_drain_len: assert property (@(posedge clk) disable iff (reset)
    $fell(sum_mult_e_en) |-> drain_len == accel_pkg::N_PE)
    else $error("drain window ended after %0d cycles", drain_len);

  a_row_start: assert property (@(posedge clk) disable iff (reset)
    $rose(sum_mult_e_en) |-> row_idx == '0)
    else $error("drain did not start at channel 0");

  a_row_step: assert property (@(posedge clk) disable iff (reset)
    (sum_mult_e_en && $past(sum_mult_e_en)) |-> row_idx == $past(row_idx) + 1'b1)
    else $error("row_idx skipped during the drain");

  a_no_term: assert property (@(posedge clk) disable iff (reset)
    sum_mult_e_en |-> !term_active)
    else $error("term taken during the drain");

  // end of tile is a single pulse
  a_end_pulse: assert property (@(posedge clk) disable iff (reset)
    relu_scale_add_end |=> !relu_scale_add_end)
    else $error("relu_scale_add_end held longer than one cycle");

endmodule

/* bench/tb_conv_tile.sv */
`timescale 1ns/1ns

module tb_conv_tile;

  localparam int N_ROWS    = 10;
  localparam int MAX_TERMS = 41;

  logic                                        clk;
  logic                                        reset;
  logic                                        re_fm_en;
  logic                                        mode;
  logic [accel_pkg::CNT_W-1:0]                 nif_mult_k_mult_k;
  logic signed [accel_pkg::ACT_W-1:0]          act_in;
  logic [accel_pkg::N_PE*accel_pkg::WGT_W-1:0] weight_in;
  logic [accel_pkg::SCALE_W-1:0]               scale_e;
  logic signed [accel_pkg::BIAS_W-1:0]         bias;
  logic                                        q_valid;
  logic signed [accel_pkg::OUT_W-1:0]          q_data;
  logic [accel_pkg::IDX_W-1:0]                 q_channel;
  logic                                        tile_done;

  // stimulus table with one tile per row
  string row_name  [N_ROWS];
  int    row_nif   [N_ROWS];
  bit    row_mode  [N_ROWS];
  int    row_scale [N_ROWS];
  int    row_bias  [N_ROWS];
  int    row_gap   [N_ROWS];   // idle cycles before the start
  int    row_span  [N_ROWS];   // random operands in -(span-1)..span-1
  int    n_rows;

  int     act_mem [MAX_TERMS];
  int     wgt_mem [MAX_TERMS][accel_pkg::N_PE];
  integer seed;
  int     cycle_count;
  int     cycle_limit;

  conv_tile_top dut0 (.*);

  bind tile_ctrl conv_tile_chk u_chk (
    .clk                (clk),
    .reset              (reset),
    .term_active        (term_active),
    .sum_mult_e_en      (pc.sum_mult_e_en),
    .row_idx            (pc.row_idx),
    .relu_scale_add_end (pc.relu_scale_add_end)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout, no tile completed within %0d cycles", cycle_limit);
      $display("test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic add_row(input string name, input int nif, input bit md, input int scale,
                         input int bs, input int gap, input int span);
    row_name[n_rows]  = name;
    row_nif[n_rows]   = nif;
    row_mode[n_rows]  = md;
    row_scale[n_rows] = scale;
    row_bias[n_rows]  = bs;
    row_gap[n_rows]   = gap;
    row_span[n_rows]  = span;
    n_rows++;
  endtask

  task automatic check_value(input string label, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %0d actual %0d", label, expected, actual);
      $display("test failed");
      $fatal(1, "value mismatch in %s", label);
    end
  endtask

  task automatic wait_drive_slot();
    @(posedge clk);
    #2;
  endtask

  // scale and bias then optional relu and >>> 16 with int8 saturate
  function automatic longint requant_model(input longint dot, input int scale,
                                           input int bs, input bit relu);
    longint v;
    v = dot * scale + bs;
    if (relu && v < 0) v = 0;
    v = v >>> 16;
    if (v > 127) v = 127;
    else if (v < -128) v = -128;
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // one tile of terms in and eight results out
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_tile(input int r);
    int     t_len;
    int     cyc;
    int     n_out;
    int     first_q;
    bit     done;
    longint dot;
    longint expect_q [accel_pkg::N_PE];
    t_len   = row_nif[r] + 1;
    first_q = t_len + accel_pkg::N_PE + 3;
    for (int t = 0; t < t_len; t++) begin
      act_mem[t] = $random(seed) % row_span[r];
      for (int i = 0; i < accel_pkg::N_PE; i++) begin
        wgt_mem[t][i] = $random(seed) % row_span[r];
      end
    end
    for (int i = 0; i < accel_pkg::N_PE; i++) begin
      dot = 0;
      for (int t = 0; t < t_len; t++) dot += act_mem[t] * wgt_mem[t][i];
      expect_q[i] = requant_model(dot, row_scale[r], row_bias[r], row_mode[r]);
    end
    cyc   = 0;
    n_out = 0;
    done  = 0;
    while (!done) begin
      wait_drive_slot();
      if (cyc == 0) begin
        nif_mult_k_mult_k = row_nif[r];
        mode              = row_mode[r];
        scale_e           = row_scale[r];
        bias              = row_bias[r];
      end
      if (cyc == 1) begin
        mode = ~row_mode[r];                // relu_on keeps the start value
      end
      // extra starts land in the term, skew and drain phases
      re_fm_en = (cyc == 0) || (cyc == 1) || (cyc == t_len + 3) ||
                 (cyc == t_len + accel_pkg::N_PE + 2);
      if (cyc < t_len) begin
        act_in = act_mem[cyc][accel_pkg::ACT_W-1:0];
        for (int i = 0; i < accel_pkg::N_PE; i++) begin
          weight_in[i*accel_pkg::WGT_W +: accel_pkg::WGT_W] =
            wgt_mem[cyc][i][accel_pkg::WGT_W-1:0];
        end
      end else begin
        act_in    = $random(seed);                  // junk while no term is valid
        weight_in = {$random(seed), $random(seed)};
      end
      @(negedge clk);
      check_value($sformatf("%s cycle %0d q_valid", row_name[r], cyc), cyc >= first_q,
                  q_valid);
      check_value($sformatf("%s cycle %0d tile_done", row_name[r], cyc),
                  cyc == first_q + accel_pkg::N_PE - 1, tile_done);
      if (q_valid) begin
        check_value($sformatf("%s ch%0d q_channel", row_name[r], n_out), n_out, q_channel);
        check_value($sformatf("%s ch%0d q_data", row_name[r], n_out), expect_q[n_out],
                    q_data);
        n_out++;
      end
      done = tile_done;
      cyc++;
    end
    check_value($sformatf("%s result count", row_name[r]), accel_pkg::N_PE, n_out);
  endtask

  initial begin
    clk               = 1'b0;
    reset             = 1'b1;
    re_fm_en          = 1'b0;
    mode              = 1'b0;
    nif_mult_k_mult_k = '0;
    act_in            = '0;
    weight_in         = '0;
    scale_e           = '0;
    bias              = '0;
    seed              = 32'h88bed4b9;
    n_rows            = 0;
    cycle_count       = 0;
    cycle_limit       = 0;
    // 65535 with a half lsb bias is unity gain for small sums
    add_row("dot_mode0",      7, 0, 65535,     32768, 3, 4);
    add_row("dot_back2back",  7, 0, 65535,     32768, 0, 4);
    add_row("scale_bias",    11, 0,  1234,    -70000, 0, 64);
    add_row("sat_high",       5, 0, 40000,  13107200, 2, 4);
    add_row("sat_low",        5, 0, 40000, -19660800, 0, 4);
    add_row("sat_mixed",     40, 0, 65535,         0, 1, 128);
    add_row("relu_neg",      15, 1, 65535,  -1310720, 0, 4);
    add_row("relu_scaled",    9, 1, 30000,      5000, 0, 16);
    add_row("single_term",    0, 0, 65535,     32768, 0, 11);
    add_row("long_tile",     40, 1,  2000,   -100000, 4, 32);
    for (int r = 0; r < n_rows; r++) begin
      cycle_limit += row_nif[r] + 1 + 2 * accel_pkg::N_PE + 6 + row_gap[r];
    end
    cycle_limit = 2 * cycle_limit + 20;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      repeat (row_gap[r]) begin
        wait_drive_slot();
        re_fm_en = 1'b0;
      end
      run_tile(r);
    end
    $display("test passed");
    $finish;
  end

endmodule

/* common/accel_pkg.sv */
package accel_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // array geometry
  ////////////////////////////////////////////////////////////////////////////
  localparam int N_PE  = 8;         // pes = output channels per tile
  localparam int IDX_W = 3;         // channel index
  localparam int CNT_W = 16;        // term counter, matches nif_mult_k_mult_k

  ////////////////////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int ACT_W = 8;         // signed activation
  localparam int WGT_W = 8;         // signed weight
  localparam int ACC_W = 24;        // signed accumulator

  // requantization
  localparam int SCALE_W = 16;      // unsigned scale E
  localparam int BIAS_W  = 32;      // signed bias
  localparam int PROD_W  = 40;      // acc * E plus bias headroom
  localparam int Q_SHIFT = 16;      // fixed point position of E
  localparam int OUT_W   = 8;       // int8 result

endpackage

/* common/pe_feed_if.sv */
`timescale 1ns/1ns

// skewed operand lane into one pe
interface pe_feed_if;

  logic signed [accel_pkg::ACT_W-1:0] act;
  logic signed [accel_pkg::WGT_W-1:0] weight;
  logic                               valid;  // term present this cycle
  logic                               first;  // term 0, load instead of add

  modport feeder (
    output act, weight, valid, first
  );

  modport pe (
    input act, weight, valid, first
  );

endinterface

/* common/post_ctrl_if.sv */
`timescale 1ns/1ns

// controller strobes into the requant pipeline
interface post_ctrl_if;

  logic [accel_pkg::IDX_W-1:0] row_idx;      // channel being drained
  logic sum_mult_e_en;                       // stage 1, acc * E
  logic product_add_bias_en;                 // stage 2, + bias
  logic relu_scale_en;                       // stage 3, relu/shift/sat
  logic relu_on;                             // latched mode
  logic relu_scale_add_end;                  // last channel in stage 3

  modport ctrl (
    output row_idx, sum_mult_e_en, product_add_bias_en,
    output relu_scale_en, relu_on, relu_scale_add_end
  );

  modport post (
    input row_idx, sum_mult_e_en, product_add_bias_en,
    input relu_scale_en, relu_on, relu_scale_add_end
  );

endinterface

/* hw/conv_tile_top.sv */
`timescale 1ns/1ns

module conv_tile_top (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        re_fm_en,
  input  logic                                        mode,      // 1 = relu
  input  logic [accel_pkg::CNT_W-1:0]                 nif_mult_k_mult_k,
  input  logic signed [accel_pkg::ACT_W-1:0]          act_in,
  input  logic [accel_pkg::N_PE*accel_pkg::WGT_W-1:0] weight_in, // weight i at slice i
  input  logic [accel_pkg::SCALE_W-1:0]               scale_e,
  input  logic signed [accel_pkg::BIAS_W-1:0]         bias,
  output logic                                        q_valid,
  output logic signed [accel_pkg::OUT_W-1:0]          q_data,
  output logic [accel_pkg::IDX_W-1:0]                 q_channel,
  output logic                                        tile_done
);

  logic                                             term_active;
  logic                                             term_first;
  logic [accel_pkg::N_PE-1:0][accel_pkg::ACC_W-1:0] acc_bus;

  pe_feed_if   feed [accel_pkg::N_PE] ();
  post_ctrl_if pc ();

  tile_ctrl u_ctrl (
    .clk               (clk),
    .reset             (reset),
    .re_fm_en          (re_fm_en),
    .mode              (mode),
    .nif_mult_k_mult_k (nif_mult_k_mult_k),
    .term_active       (term_active),
    .term_first        (term_first),
    .pc                (pc.ctrl)
  );

  act_skew_feeder u_feeder (
    .clk         (clk),
    .reset       (reset),
    .term_active (term_active),
    .term_first  (term_first),
    .act_in      (act_in),
    .weight_in   (weight_in),
    .feed        (feed)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pe array, one output channel each
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < accel_pkg::N_PE; i++) begin : g_pe
    mac_pe u_pe (
      .clk   (clk),
      .reset (reset),
      .feed  (feed[i].pe),
      .acc   (acc_bus[i])
    );
  end

  requant_stage u_post (
    .clk       (clk),
    .reset     (reset),
    .scale_e   (scale_e),
    .bias      (bias),
    .acc_bus   (acc_bus),
    .pc        (pc.post),
    .q_valid   (q_valid),
    .q_data    (q_data),
    .q_channel (q_channel)
  );

  // lines up with the last q_valid
  always_ff @(posedge clk) begin
    if (reset) begin
      tile_done <= 1'b0;
    end else begin
      tile_done <= pc.relu_scale_add_end;
    end
  end

endmodule

/* hw/tile_ctrl.sv */
`timescale 1ns/1ns

module tile_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         re_fm_en,
  input  logic                         mode,
  input  logic [accel_pkg::CNT_W-1:0]  nif_mult_k_mult_k,
  output logic                         term_active,
  output logic                         term_first,
  post_ctrl_if.ctrl                    pc
);

  logic                        busy;        // tile in flight, start ignored
  logic                        start;
  logic                        term_run;
  logic [accel_pkg::CNT_W-1:0] term_cnt;
  logic                        term_last;
  logic                        phase_run;   // skew then drain
  logic [accel_pkg::IDX_W:0]   phase_cnt;
  logic                        phase_last;
  logic                        bias_end;
  logic                        tile_end_d;

  ////////////////////////////////////////////////////////////////////////////
  // term counter
  ////////////////////////////////////////////////////////////////////////////
  assign start       = re_fm_en & ~busy;
  assign term_active = start | term_run;    // term 0 rides with the start
  assign term_first  = start;
  assign term_last   = term_active & (term_cnt == nif_mult_k_mult_k);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (tile_end_d) begin
      busy <= 1'b0;                         // idle the cycle after tile_done
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      term_run <= 1'b0;
      term_cnt <= '0;
    end else if (term_last) begin
      term_run <= 1'b0;
      term_cnt <= '0;
    end else if (term_active) begin
      term_run <= 1'b1;
      term_cnt <= term_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // skew + drain counter
  ////////////////////////////////////////////////////////////////////////////
  // low half of the count lets the skew settle, high half drains
  assign phase_last = phase_run & (&phase_cnt);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_run <= 1'b0;
      phase_cnt <= '0;
    end else if (term_last) begin
      phase_run <= 1'b1;
      phase_cnt <= '0;
    end else if (phase_last) begin
      phase_run <= 1'b0;
      phase_cnt <= '0;
    end else if (phase_run) begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  assign pc.sum_mult_e_en = phase_run & phase_cnt[accel_pkg::IDX_W];
  assign pc.row_idx = pc.sum_mult_e_en ? phase_cnt[accel_pkg::IDX_W-1:0] : '0;

  // enable and end-of-tile cascades
  always_ff @(posedge clk) begin
    if (reset) begin
      pc.product_add_bias_en <= 1'b0;
      pc.relu_scale_en       <= 1'b0;
      bias_end               <= 1'b0;
      pc.relu_scale_add_end  <= 1'b0;
      tile_end_d             <= 1'b0;
      pc.relu_on             <= 1'b0;
    end else begin
      pc.product_add_bias_en <= pc.sum_mult_e_en;
      pc.relu_scale_en       <= pc.product_add_bias_en;
      bias_end               <= phase_last;
      pc.relu_scale_add_end  <= bias_end;
      tile_end_d             <= pc.relu_scale_add_end;
      if (start) begin
        pc.relu_on <= mode;                 // held for the whole tile
      end
    end
  end

endmodule

/* list.f */
common/accel_pkg.sv
common/pe_feed_if.sv
common/post_ctrl_if.sv
sa/act_skew_feeder.sv
sa/mac_pe.sv
post/requant_stage.sv
hw/tile_ctrl.sv
hw/conv_tile_top.sv
bench/conv_tile_chk.sv
bench/tb_conv_tile.sv

/* post/requant_stage.sv */
`timescale 1ns/1ns

module requant_stage (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic [accel_pkg::SCALE_W-1:0]                      scale_e,
  input  logic signed [accel_pkg::BIAS_W-1:0]                bias,
  input  logic [accel_pkg::N_PE-1:0][accel_pkg::ACC_W-1:0]   acc_bus,
  post_ctrl_if.post                                          pc,
  output logic                                               q_valid,
  output logic signed [accel_pkg::OUT_W-1:0]                 q_data,
  output logic [accel_pkg::IDX_W-1:0]                        q_channel
);

  logic signed [accel_pkg::ACC_W-1:0]  acc_sel;
  logic signed [accel_pkg::PROD_W-1:0] acc_ext;
  logic signed [accel_pkg::PROD_W-1:0] scale_ext;
  logic signed [accel_pkg::PROD_W-1:0] bias_ext;
  logic signed [accel_pkg::PROD_W-1:0] prod_s1;
  logic [accel_pkg::IDX_W-1:0]         ch_s1;
  logic signed [accel_pkg::PROD_W-1:0] sum_s2;
  logic [accel_pkg::IDX_W-1:0]         ch_s2;
  logic signed [accel_pkg::PROD_W-1:0] relu_v;
  logic signed [accel_pkg::PROD_W-1:0] shifted;
  logic                                sat_hi;
  logic                                sat_lo;

  assign acc_sel   = acc_bus[pc.row_idx];
  assign acc_ext   = {{(accel_pkg::PROD_W-accel_pkg::ACC_W){acc_sel[accel_pkg::ACC_W-1]}},
                      acc_sel};
  assign scale_ext = {{(accel_pkg::PROD_W-accel_pkg::SCALE_W){1'b0}}, scale_e}; // E unsigned
  assign bias_ext  = {{(accel_pkg::PROD_W-accel_pkg::BIAS_W){bias[accel_pkg::BIAS_W-1]}},
                      bias};

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 and 2
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (pc.sum_mult_e_en) begin
      prod_s1 <= acc_ext * scale_ext;
      ch_s1   <= pc.row_idx;
    end
    if (pc.product_add_bias_en) begin
      sum_s2 <= prod_s1 + bias_ext;
      ch_s2  <= ch_s1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 3, relu + shift + int8 saturate
  ////////////////////////////////////////////////////////////////////////////
  assign relu_v  = (pc.relu_on && sum_s2[accel_pkg::PROD_W-1]) ? '0 : sum_s2;
  assign shifted = relu_v >>> accel_pkg::Q_SHIFT;

  // out of range when bits above the int8 sign disagree with it
  assign sat_hi = ~shifted[accel_pkg::PROD_W-1] &
                  (|shifted[accel_pkg::PROD_W-1:accel_pkg::OUT_W-1]);
  assign sat_lo =  shifted[accel_pkg::PROD_W-1] &
                  ~(&shifted[accel_pkg::PROD_W-1:accel_pkg::OUT_W-1]);

  always_ff @(posedge clk) begin
    if (pc.relu_scale_en) begin
      q_channel <= ch_s2;
      if (sat_hi) begin
        q_data <= {1'b0, {(accel_pkg::OUT_W-1){1'b1}}};     // +127
      end else if (sat_lo) begin
        q_data <= {1'b1, {(accel_pkg::OUT_W-1){1'b0}}};     // -128
      end else begin
        q_data <= shifted[accel_pkg::OUT_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= pc.relu_scale_en;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the conv tile testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_conv_tile -f list.f -o sim_tb_conv_tile

sim_status=0
./obj_dir/sim_tb_conv_tile > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "simulation ended without a result, exit status $sim_status"
  exit 1
fi
echo "simulation PASSED"

/* sa/act_skew_feeder.sv */
`timescale 1ns/1ns

module act_skew_feeder (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        term_active,
  input  logic                                        term_first,
  input  logic signed [accel_pkg::ACT_W-1:0]          act_in,
  input  logic [accel_pkg::N_PE*accel_pkg::WGT_W-1:0] weight_in,
  pe_feed_if.feeder                                   feed [accel_pkg::N_PE]
);

  logic signed [accel_pkg::ACT_W-1:0] act_dly [accel_pkg::N_PE];
  logic [accel_pkg::N_PE-1:0]         valid_dly;   // bit i is i+1 deep
  logic [accel_pkg::N_PE-1:0]         first_dly;

  // activation shared by all lanes, pe i taps stage i
  always_ff @(posedge clk) begin
    act_dly[0] <= act_in;
    for (int s = 1; s < accel_pkg::N_PE; s++) begin
      act_dly[s] <= act_dly[s-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_dly <= '0;
      first_dly <= '0;
    end else begin
      valid_dly <= {valid_dly[accel_pkg::N_PE-2:0], term_active};
      first_dly <= {first_dly[accel_pkg::N_PE-2:0], term_first};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // per-lane weight delay, triangular
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < accel_pkg::N_PE; i++) begin : g_lane
    logic signed [accel_pkg::WGT_W-1:0] wgt_dly [i+1];

    always_ff @(posedge clk) begin
      wgt_dly[0] <= weight_in[i*accel_pkg::WGT_W +: accel_pkg::WGT_W];
      for (int s = 1; s <= i; s++) begin
        wgt_dly[s] <= wgt_dly[s-1];
      end
    end

    assign feed[i].act    = act_dly[i];
    assign feed[i].weight = wgt_dly[i];     // last stage of this lane
    assign feed[i].valid  = valid_dly[i];
    assign feed[i].first  = first_dly[i];
  end

endmodule

/* sa/mac_pe.sv */
`timescale 1ns/1ns

module mac_pe (
  input  logic                              clk,
  input  logic                              reset,
  pe_feed_if.pe                             feed,
  output logic signed [accel_pkg::ACC_W-1:0] acc
);

  logic signed [accel_pkg::ACT_W+accel_pkg::WGT_W-1:0] prod;
  logic signed [accel_pkg::ACC_W-1:0]                  prod_ext;

  assign prod = feed.act * feed.weight;

  // sign extend product to accumulator width
  assign prod_ext = {{(accel_pkg::ACC_W-accel_pkg::ACT_W-accel_pkg::WGT_W)
                      {prod[accel_pkg::ACT_W+accel_pkg::WGT_W-1]}}, prod};

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (feed.valid) begin
      if (feed.first) begin
        acc <= prod_ext;                    // new tile, drop old sum
      end else begin
        acc <= acc + prod_ext;
      end
    end
    // no term, hold for the drain
  end

endmodule
